/* atm_pager.sv */
`timescale 1ns/1ns
`include "pager_defs.svh"

module atm_pager
#(
	parameter int WINDOW = 0 // which za[15:14] this block serves
)
(
	input  logic                  fclk,
	input  logic                  arst_n,
	input  pager_pkg::zaddr_t     za,
	input  pager_pkg::zdata_t     zd,
	input  logic                  mreq_n, // tracked for dos entry and exit
	input  logic                  m1_n,
	input  logic                  zpos, // z80 clock rising edge strobe
	input  logic                  zneg, // z80 clock falling edge strobe
	input  logic                  pager_off,
	input  logic                  pent1m_rom,
	input  pager_pkg::pent_page_t pent1m_page,
	input  logic                  pent1m_ram0_0,
	input  logic                  pent1m_1m_on,
	input  logic                  in_nmi, // nmi handler wants the last ram page at 0000
	input  logic                  atm_f7_wr,
	input  logic                  dos, // current dos state, picks the rom half
	output logic                  dos_turn_on,
	output logic                  dos_turn_off,
	output logic                  zclk_stall,
	output pager_pkg::page_t      page,
	output logic                  romnram
);

	localparam pager_pkg::win_idx_t WIN = pager_pkg::win_idx_t'(WINDOW);
	// counter runs load..7 then wraps to 0, giving STALL_CYCLES-1 cycles after turn-on
	localparam logic [2:0] STALL_LOAD = 3'(8 - (`PAGER_STALL_CYCLES - 1));

	pager_pkg::page_t pages [0:1]; // one page per map, map picked by pent1m_rom
	logic [1:0]       ramnrom; // 1 = ram, 0 = rom
	logic [1:0]       dos_7ffd; // ram: mix in 7FFD bits, rom: follow dos
	pager_pkg::page_t next_page;
	logic             next_romnram;
	logic             win_hit; // za points into this window
	logic             m1_n_reg; // m1_n sampled at zpos
	logic             mreq_n_reg; // mreq_n sampled at zneg
	logic             fetch_stb; // start of an m1 fetch in this window
	logic [2:0]       stall_count;

	assign win_hit = (za[15:14] == WIN);

	// page registers, written through xFF7 and x7F7
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pages[0] <= '0;
			pages[1] <= '0;
			ramnrom  <= '0;
			dos_7ffd <= '0;
		end
		else if (atm_f7_wr && win_hit)
		begin
			if (za[11]) // xFF7, 1 MB pages with flags in d7..d6
			begin
				pages[pent1m_rom]    <= ~{2'b11, zd[5:0]};
				ramnrom[pent1m_rom]  <= zd[6];
				dos_7ffd[pent1m_rom] <= zd[7];
			end
			else // x7F7, full 4 MB ram page
			begin
				pages[pent1m_rom]   <= ~zd;
				ramnrom[pent1m_rom] <= 1'b1; // mix bit keeps its value
			end
		end
	end

	// page rule, highest priority first
	always_comb
	begin
		next_page    = pages[pent1m_rom];
		next_romnram = ~ramnrom[pent1m_rom];
		if (pager_off)
		begin
			next_page    = '1; // service rom
			next_romnram = 1'b1;
		end
		else if ((WIN == 2'd0) && in_nmi)
		begin
			next_page    = '1; // last ram page
			next_romnram = 1'b0;
		end
		else if ((WIN == 2'd0) && pent1m_ram0_0)
		begin
			next_page    = '0;
			next_romnram = 1'b0;
		end
		else if (dos_7ffd[pent1m_rom])
		begin
			if (ramnrom[pent1m_rom])
			begin
				if (pent1m_1m_on)
					next_page = {pages[pent1m_rom][7:6], pent1m_page}; // whole 1 MB
				else
					next_page = {pages[pent1m_rom][7:3], pent1m_page[2:0]}; // 128 KB
			end
			else
				next_page = {pages[pent1m_rom][7:1], dos}; // dos picks the rom half
		end
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			page    <= '1;
			romnram <= 1'b1; // same as pager off
		end
		else
		begin
			page    <= next_page;
			romnram <= next_romnram;
		end
	end

	// z80 control sampling on its own clock edges
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			m1_n_reg   <= 1'b1;
			mreq_n_reg <= 1'b1;
		end
		else
		begin
			if (zpos)
				m1_n_reg <= m1_n;
			if (zneg)
				mreq_n_reg <= mreq_n;
		end
	end

	assign fetch_stb = zneg & win_hit & ~m1_n_reg & ~mreq_n & mreq_n_reg;

	// trdos entry at 3Dxx from the 7FFD-mixed rom of map 1
	assign dos_turn_on  = fetch_stb & (za[13:8] == 6'h3D) & dos_7ffd[1] & ~ramnrom[1] &
		pent1m_rom;
	assign dos_turn_off = fetch_stb & ramnrom[pent1m_rom]; // any fetch from ram leaves dos

	// hold the z80 clock while the rom chip switches halves
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			stall_count <= '0;
		else if (dos_turn_on)
			stall_count <= STALL_LOAD; // 101 -> 110 -> 111 -> 000
		else if (stall_count[2])
			stall_count <= stall_count + 3'd1;
	end

	assign zclk_stall = dos_turn_on | stall_count[2];

endmodule

/* memory_pager.sv */
`timescale 1ns/1ns
`include "pager_defs.svh"

module memory_pager
(
	input  logic              fclk,
	input  logic              arst_n,
	input  pager_pkg::zaddr_t za,
	input  pager_pkg::zdata_t zd,
	input  logic              iorq_n,
	input  logic              wr_n,
	input  logic              mreq_n,
	input  logic              m1_n,
	input  logic              zpos,
	input  logic              zneg,
	input  logic              in_nmi,
	output pager_pkg::page_t  page,
	output logic              romnram,
	output logic              dos,
	output logic              zclk_stall
);

	logic                                  atm_f7_wr;
	logic                                  pager_off;
	logic                                  pent1m_rom;
	pager_pkg::pent_page_t                 pent1m_page;
	logic                                  pent1m_ram0_0;
	logic                                  pent1m_1m_on;
	pager_pkg::page_t [`PAGER_WINDOWS-1:0] win_page; // one entry per window
	logic [`PAGER_WINDOWS-1:0]             win_romnram;
	logic [`PAGER_WINDOWS-1:0]             win_dos_on;
	logic [`PAGER_WINDOWS-1:0]             win_dos_off;
	logic [`PAGER_WINDOWS-1:0]             win_stall;

	port_decoder port_decoder_inst
	(
		.fclk          (fclk),
		.arst_n        (arst_n),
		.za            (za),
		.zd            (zd),
		.iorq_n        (iorq_n),
		.wr_n          (wr_n),
		.atm_f7_wr     (atm_f7_wr),
		.pager_off     (pager_off),
		.pent1m_rom    (pent1m_rom),
		.pent1m_page   (pent1m_page),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.pent1m_1m_on  (pent1m_1m_on)
	);

	for (genvar w = 0; w < `PAGER_WINDOWS; w++)
	begin : g_window
		atm_pager #(.WINDOW(w)) atm_pager_inst
		(
			.fclk          (fclk),
			.arst_n        (arst_n),
			.za            (za),
			.zd            (zd),
			.mreq_n        (mreq_n),
			.m1_n          (m1_n),
			.zpos          (zpos),
			.zneg          (zneg),
			.pager_off     (pager_off),
			.pent1m_rom    (pent1m_rom),
			.pent1m_page   (pent1m_page),
			.pent1m_ram0_0 (pent1m_ram0_0),
			.pent1m_1m_on  (pent1m_1m_on),
			.in_nmi        (in_nmi),
			.atm_f7_wr     (atm_f7_wr),
			.dos           (dos), // shared dos flag fed back
			.dos_turn_on   (win_dos_on[w]),
			.dos_turn_off  (win_dos_off[w]),
			.zclk_stall    (win_stall[w]),
			.page          (win_page[w]),
			.romnram       (win_romnram[w])
		);
	end

	window_select window_select_inst
	(
		.fclk        (fclk),
		.arst_n      (arst_n),
		.za          (za),
		.win_page    (win_page),
		.win_romnram (win_romnram),
		.win_dos_on  (win_dos_on),
		.win_dos_off (win_dos_off),
		.win_stall   (win_stall),
		.page        (page),
		.romnram     (romnram),
		.dos         (dos),
		.zclk_stall  (zclk_stall)
	);

endmodule

/* pager_defs.svh */
`ifndef PAGER_DEFS_SVH
`define PAGER_DEFS_SVH

// z80 bus widths
`define PAGER_ADDR_W 16
`define PAGER_DATA_W 8

// physical page number, 256 pages of 16 KB make 4 MB
`define PAGER_PAGE_W 8

// 16 KB windows in the 64 KB z80 space
`define PAGER_WINDOWS 4

// port addresses
`define PAGER_PORT_7FFD 16'h7FFD // pentagon 1024 memory port, full decode
`define PAGER_PORT_F7 8'hF7 // atm page ports xxF7, low byte only
`define PAGER_PORT_77 8'h77 // atm system port xx77, low byte only

// fclk cycles of zclk_stall after a dos entry, turn-on cycle included
`define PAGER_STALL_CYCLES 4

`endif

/* pager_pkg.sv */
`include "pager_defs.svh"

package pager_pkg;

	// z80 address bus
	typedef logic [`PAGER_ADDR_W-1:0] zaddr_t;

	// z80 data bus
	typedef logic [`PAGER_DATA_W-1:0] zdata_t;

	// physical page number going to the memory decoder
	typedef logic [`PAGER_PAGE_W-1:0] page_t;

	// pentagon 1 MB page assembled from port 7FFD
	typedef logic [5:0] pent_page_t;

	// window number, same as za[15:14]
	typedef logic [1:0] win_idx_t;

endpackage

/* port_decoder.sv */
`timescale 1ns/1ns
`include "pager_defs.svh"

module port_decoder
(
	input  logic                  fclk,
	input  logic                  arst_n,
	input  pager_pkg::zaddr_t     za, // z80 address bus
	input  pager_pkg::zdata_t     zd, // z80 data bus, latched on port writes
	input  logic                  iorq_n,
	input  logic                  wr_n,
	output logic                  atm_f7_wr, // one-cycle strobe for the xxF7 page ports
	output logic                  pager_off, // atm PEN inverted, rom everywhere
	output logic                  pent1m_rom, // d4 of 7FFD, selects the map
	output pager_pkg::pent_page_t pent1m_page, // 1 MB page from 7FFD
	output logic                  pent1m_ram0_0, // ram page 0 into window 0
	output logic                  pent1m_1m_on // 1 MB addressing of 7FFD
);

	logic wr_n_reg; // wr_n one fclk back
	logic io_wr_stb; // first fclk of an i/o write
	logic port_7ffd_hit;
	logic port_77_hit;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			wr_n_reg <= 1'b1;
		else
			wr_n_reg <= wr_n;
	end

	// wr_n falls while iorq_n is low
	assign io_wr_stb = ~iorq_n & ~wr_n & wr_n_reg;

	assign atm_f7_wr     = io_wr_stb & (za[7:0] == `PAGER_PORT_F7);
	assign port_7ffd_hit = io_wr_stb & (za == `PAGER_PORT_7FFD); // full 16-bit decode
	assign port_77_hit   = io_wr_stb & (za[7:0] == `PAGER_PORT_77);

	// pentagon 1024 port 7FFD
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pent1m_page <= '0;
			pent1m_rom  <= 1'b0; // boot rom select
		end
		else if (port_7ffd_hit)
		begin
			pent1m_page <= {zd[7:5], zd[2:0]}; // d7..d5 are the 1 MB extension bits
			pent1m_rom  <= zd[4];
		end
	end

	// atm system port xx77
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pager_off     <= 1'b1; // boot with the service rom in every window
			pent1m_1m_on  <= 1'b0;
			pent1m_ram0_0 <= 1'b0;
		end
		else if (port_77_hit)
		begin
			pager_off     <= ~zd[0]; // d0 is PEN, 1 turns paging on
			pent1m_1m_on  <= zd[1];
			pent1m_ram0_0 <= zd[2];
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the memory pager testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ns --top-module tb_memory_pager \
	-f sources.f -o sim_memory_pager
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/sim_memory_pager > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* sources.f */
+incdir+.
pager_pkg.sv
port_decoder.sv
atm_pager.sv
window_select.sv
memory_pager.sv
tb_memory_pager.sv

/* tb_memory_pager.sv */
`timescale 1ns/1ns
`include "pager_defs.svh"

module tb_memory_pager;

	localparam int OP_CHK   = 0; // move za and look at the outputs
	localparam int OP_IOW   = 1; // z80 port write
	localparam int OP_FETCH = 2; // m1 opcode fetch
	localparam int OP_NMI   = 3; // in_nmi level taken from data[0]
	localparam int RND_NONE = 0;
	localparam int RND_NEW  = 1; // random data, kept in a slot
	localparam int RND_OLD  = 2; // expect the x7F7 page of an earlier slot

	logic              fclk = 1'b0;
	logic              arst_n;
	pager_pkg::zaddr_t za;
	pager_pkg::zdata_t zd;
	logic              iorq_n;
	logic              wr_n;
	logic              mreq_n;
	logic              m1_n;
	logic              zpos = 1'b0; // first cycle after init is a zpos cycle
	logic              zneg = 1'b1;
	logic              in_nmi;
	pager_pkg::page_t  page;
	logic              romnram;
	logic              dos;
	logic              zclk_stall;

	string             t_name [$];
	int                t_op [$];
	pager_pkg::zaddr_t t_addr [$];
	pager_pkg::zdata_t t_data [$];
	int                t_rnd [$];
	logic [2:0]        t_slot [$];
	pager_pkg::page_t  t_page [$];
	logic              t_romnram [$];
	logic              t_dos [$];
	int                t_stall [$];

	pager_pkg::zdata_t slot_data [0:7]; // random x7F7 data per slot
	int                seed = 32'ha290;
	int                stall_total = 0; // fclk cycles seen with zclk_stall high

	memory_pager memory_pager_inst
	(
		.fclk       (fclk),
		.arst_n     (arst_n),
		.za         (za),
		.zd         (zd),
		.iorq_n     (iorq_n),
		.wr_n       (wr_n),
		.mreq_n     (mreq_n),
		.m1_n       (m1_n),
		.zpos       (zpos),
		.zneg       (zneg),
		.in_nmi     (in_nmi),
		.page       (page),
		.romnram    (romnram),
		.dos        (dos),
		.zclk_stall (zclk_stall)
	);

	always #50 fclk = ~fclk; // 100 ns period

	// z80 clock edges alternate every fclk
	always @(posedge fclk)
	begin
		#10;
		zpos <= zneg;
		zneg <= zpos;
	end

	always @(negedge fclk)
	begin
		if (zclk_stall === 1'b1)
			stall_total <= stall_total + 1;
	end

	task automatic add_test(input string name, input int op, input pager_pkg::zaddr_t addr,
		input pager_pkg::zdata_t data, input int rnd, input logic [2:0] slot,
		input pager_pkg::page_t pg, input logic rn, input logic ds, input int stall);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_rnd.push_back(rnd);
		t_slot.push_back(slot);
		t_page.push_back(pg);
		t_romnram.push_back(rn);
		t_dos.push_back(ds);
		t_stall.push_back(stall);
	endtask

	task automatic end_with_failure();
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_page(input string name, input pager_pkg::page_t exp,
		input pager_pkg::page_t act);
		if (act !== exp)
		begin
			$display("ERROR: %s page expected %02h actual %02h", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input string what, input logic exp,
		input logic act);
		if (act !== exp)
		begin
			$display("ERROR: %s %s expected %b actual %b", name, what, exp, act);
			end_with_failure();
		end
	endtask

	task automatic check_stall(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("ERROR: %s stall cycles expected %0d actual %0d", name, exp, act);
			end_with_failure();
		end
	endtask

	task automatic look_at(input pager_pkg::zaddr_t addr);
		@(posedge fclk);
		#10;
		za = addr; // window output follows za in the same cycle
	endtask

	task automatic io_write(input pager_pkg::zaddr_t addr, input pager_pkg::zdata_t data);
		@(posedge fclk);
		#10;
		za     = addr;
		zd     = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		@(posedge fclk); // closes the strobe cycle
		#10;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		@(posedge fclk); // per-window page now registered
	endtask

	task automatic set_nmi(input pager_pkg::zaddr_t addr, input logic level);
		@(posedge fclk);
		#10;
		za     = addr;
		in_nmi = level;
		repeat (2) @(posedge fclk);
	endtask

	task automatic m1_fetch(input pager_pkg::zaddr_t addr);
		@(posedge fclk);
		while (zpos) // want the next cycle to be a zpos cycle
			@(posedge fclk);
		#10;
		za   = addr;
		m1_n = 1'b0; // sampled at zpos
		@(posedge fclk);
		#10;
		mreq_n = 1'b0; // falls in the zneg cycle
		@(posedge fclk);
		#10;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		@(posedge fclk); // rom page picks up dos one edge later
	endtask

	// name, op, address, data, random mode, slot, page, romnram, dos, stall cycles
	task automatic build_table();
		add_test("reset_w0",    OP_CHK,   16'h0000, 8'h00, RND_NONE, 3'd0, 8'hFF, 1'b1, 1'b0, 0);
		add_test("reset_w1",    OP_CHK,   16'h4000, 8'h00, RND_NONE, 3'd0, 8'hFF, 1'b1, 1'b0, 0);
		add_test("reset_w2",    OP_CHK,   16'h8000, 8'h00, RND_NONE, 3'd0, 8'hFF, 1'b1, 1'b0, 0);
		add_test("reset_w3",    OP_CHK,   16'hC000, 8'h00, RND_NONE, 3'd0, 8'hFF, 1'b1, 1'b0, 0);
		add_test("pager_on",    OP_IOW,   16'h0077, 8'h01, RND_NONE, 3'd0, 8'h00, 1'b1, 1'b0, 0);
		add_test("x7f7_w0",     OP_IOW,   16'h37F7, 8'h00, RND_NEW,  3'd0, 8'h00, 1'b0, 1'b0, 0);
		add_test("x7f7_w1",     OP_IOW,   16'h77F7, 8'h00, RND_NEW,  3'd1, 8'h00, 1'b0, 1'b0, 0);
		add_test("x7f7_w2",     OP_IOW,   16'hB7F7, 8'h00, RND_NEW,  3'd2, 8'h00, 1'b0, 1'b0, 0);
		add_test("x7f7_w3",     OP_IOW,   16'hF7F7, 8'h00, RND_NEW,  3'd3, 8'h00, 1'b0, 1'b0, 0);
		add_test("keep_w0",     OP_CHK,   16'h0000, 8'h00, RND_OLD,  3'd0, 8'h00, 1'b0, 1'b0, 0);
		add_test("keep_w1",     OP_CHK,   16'h4000, 8'h00, RND_OLD,  3'd1, 8'h00, 1'b0, 1'b0, 0);
		add_test("keep_w2",     OP_CHK,   16'h8000, 8'h00, RND_OLD,  3'd2, 8'h00, 1'b0, 1'b0, 0);
		add_test("map1_sel",    OP_IOW,   16'h7FFD, 8'h10, RND_NONE, 3'd0, 8'h00, 1'b1, 1'b0, 0);
		add_test("map1_w1",     OP_IOW,   16'h77F7, 8'h00, RND_NEW,  3'd5, 8'h00, 1'b0, 1'b0, 0);
		add_test("map1_w2",     OP_IOW,   16'hB7F7, 8'h00, RND_NEW,  3'd6, 8'h00, 1'b0, 1'b0, 0);
		add_test("map0_sel",    OP_IOW,   16'h7FFD, 8'h00, RND_OLD,  3'd1, 8'h00, 1'b0, 1'b0, 0);
		add_test("map0_w0",     OP_CHK,   16'h0000, 8'h00, RND_OLD,  3'd0, 8'h00, 1'b0, 1'b0, 0);
		add_test("map0_w3",     OP_CHK,   16'hC000, 8'h00, RND_OLD,  3'd3, 8'h00, 1'b0, 1'b0, 0);
		add_test("xff7_w2_rom", OP_IOW,   16'hBFF7, 8'h05, RND_NONE, 3'd0, 8'h3A, 1'b1, 1'b0, 0);
		add_test("xff7_w3_mix", OP_IOW,   16'hFFF7, 8'hC9, RND_NONE, 3'd0, 8'h30, 1'b0, 1'b0, 0);
		add_test("mix_7ffd",    OP_IOW,   16'h7FFD, 8'hE5, RND_OLD,  3'd1, 8'h00, 1'b0, 1'b0, 0);
		add_test("mix_128k",    OP_CHK,   16'hC000, 8'h00, RND_NONE, 3'd0, 8'h35, 1'b0, 1'b0, 0);
		add_test("mix_1m",      OP_IOW,   16'hC077, 8'h03, RND_NONE, 3'd0, 8'h3D, 1'b0, 1'b0, 0);
		add_test("ram0_0_w0",   OP_IOW,   16'h0077, 8'h07, RND_NONE, 3'd0, 8'h00, 1'b0, 1'b0, 0);
		add_test("ram0_0_w3",   OP_CHK,   16'hC000, 8'h00, RND_NONE, 3'd0, 8'h3D, 1'b0, 1'b0, 0);
		add_test("nmi_w0",      OP_NMI,   16'h0000, 8'h01, RND_NONE, 3'd0, 8'hFF, 1'b0, 1'b0, 0);
		add_test("nmi_w2",      OP_NMI,   16'h8000, 8'h01, RND_NONE, 3'd0, 8'h3A, 1'b1, 1'b0, 0);
		add_test("nmi_off",     OP_NMI,   16'h0000, 8'h00, RND_NONE, 3'd0, 8'h00, 1'b0, 1'b0, 0);
		add_test("ram0_0_off",  OP_IOW,   16'h0077, 8'h01, RND_OLD,  3'd0, 8'h00, 1'b0, 1'b0, 0);
		add_test("map1_again",  OP_IOW,   16'h7FFD, 8'h10, RND_OLD,  3'd5, 8'h00, 1'b0, 1'b0, 0);
		add_test("dos_cfg",     OP_IOW,   16'h3FF7, 8'h82, RND_NONE, 3'd0, 8'h3C, 1'b1, 1'b0, 0);
		add_test("dos_entry",   OP_FETCH, 16'h3D00, 8'h00, RND_NONE, 3'd0, 8'h3D, 1'b1, 1'b1,
			`PAGER_STALL_CYCLES);
		add_test("dos_exit",    OP_FETCH, 16'h8000, 8'h00, RND_OLD,  3'd6, 8'h00, 1'b0, 1'b0, 0);
		add_test("dos_exit_w0", OP_CHK,   16'h0000, 8'h00, RND_NONE, 3'd0, 8'h3C, 1'b1, 1'b0, 0);
	endtask

	initial
	begin
		int limit_ns;
		#1; // table is built at time 0
		limit_ns = t_name.size() * 40 * 100;
		#(limit_ns);
		$display("timeout: the tests did not finish within %0d ns", limit_ns);
		end_with_failure();
	end

	initial
	begin
		pager_pkg::page_t  exp_page;
		logic              exp_romnram;
		pager_pkg::zdata_t data;
		int                stall_start;
		arst_n = 1'b0;
		za     = '0;
		zd     = '0;
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		in_nmi = 1'b0;
		build_table();
		repeat (3) @(posedge fclk);
		#10;
		arst_n = 1'b1;
		foreach (t_name[i])
		begin
			exp_page    = t_page[i];
			exp_romnram = t_romnram[i];
			data        = t_data[i];
			if (t_rnd[i] == RND_NEW)
			begin
				data                 = pager_pkg::zdata_t'($random(seed));
				slot_data[t_slot[i]] = data;
			end
			if (t_rnd[i] != RND_NONE)
			begin
				exp_page    = ~slot_data[t_slot[i]]; // x7F7 stores the inverse as ram
				exp_romnram = 1'b0;
			end
			stall_start = stall_total;
			case (t_op[i])
				OP_IOW:   io_write(t_addr[i], data);
				OP_FETCH: m1_fetch(t_addr[i]);
				OP_NMI:   set_nmi(t_addr[i], data[0]);
				default:  look_at(t_addr[i]);
			endcase
			@(negedge fclk);
			check_page(t_name[i], exp_page, page);
			check_bit(t_name[i], "romnram", exp_romnram, romnram);
			check_bit(t_name[i], "dos", t_dos[i], dos);
			repeat (`PAGER_STALL_CYCLES + 1) @(posedge fclk); // let any stall run out
			check_stall(t_name[i], t_stall[i], stall_total - stall_start);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* window_select.sv */
`timescale 1ns/1ns
`include "pager_defs.svh"

module window_select
(
	input  logic                                       fclk,
	input  logic                                       arst_n,
	input  pager_pkg::zaddr_t                          za,
	input  pager_pkg::page_t [`PAGER_WINDOWS-1:0]      win_page, // page of each window
	input  logic [`PAGER_WINDOWS-1:0]                  win_romnram,
	input  logic [`PAGER_WINDOWS-1:0]                  win_dos_on, // dos entry pulses
	input  logic [`PAGER_WINDOWS-1:0]                  win_dos_off, // dos exit pulses
	input  logic [`PAGER_WINDOWS-1:0]                  win_stall,
	output pager_pkg::page_t                           page, // to the memory decoder
	output logic                                       romnram,
	output logic                                       dos,
	output logic                                       zclk_stall
);

	pager_pkg::win_idx_t win_sel; // addressed window
	logic                any_dos_on;
	logic                any_dos_off;

	assign win_sel = za[15:14];

	// memory side follows za with no delay
	assign page    = win_page[win_sel];
	assign romnram = win_romnram[win_sel];

	assign any_dos_on  = |win_dos_on;
	assign any_dos_off = |win_dos_off;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			dos <= 1'b0;
		else if (any_dos_on) // entry wins over exit
			dos <= 1'b1;
		else if (any_dos_off)
			dos <= 1'b0;
	end

	// any window may ask for the stall
	assign zclk_stall = |win_stall;

endmodule
